/* rtl/smc_pkg.sv */
// Single accesses only with no multi-access sequencing and no half-cycle write strobes
package smc_pkg;

   // --------------------
   // Widths
   // --------------------
   localparam int SMC_WS_W = 8;          // Wait-state count
   localparam int SMC_OE_W = 2;          // Read-strobe delay
   localparam int SMC_BE_W = 4;          // Byte lanes on the external bus

   // --------------------
   // Access state
   // --------------------
   // Encoding kept compact, two bits cover all four phases
   typedef enum logic [1:0]
   {
      SMC_IDLE  = 2'd0,                  // No access in progress
      SMC_LE    = 2'd1,                  // Address setup
      SMC_RW    = 2'd2,                  // Read/write phase, stretched by ws
      SMC_FLOAT = 2'd3                   // Read turnaround
   } smc_state_t;

   // --------------------
   // Access request
   // --------------------
   // Presented with valid_access for one cycle only
   typedef struct packed
   {
      logic                cs;           // Chip select
      logic                n_read;       // Low for read, high for write
      logic [SMC_BE_W-1:0] n_be;         // Byte enables, active low
      logic [SMC_WS_W-1:0] ws;           // Extra RW cycles
      logic [SMC_OE_W-1:0] oete;         // Read strobe held off this many RW cycles
   } smc_req_t;

   // --------------------
   // External strobes
   // --------------------
   // Every bit active low, idle value is all ones
   typedef struct packed
   {
      logic                n_rd;         // Read strobe
      logic                n_ext_oe;     // Bus-driver enable, writes only
      logic [SMC_BE_W-1:0] n_we;         // Per-byte write enables
      logic                n_wr;         // Write strobe
   } smc_strobe_t;

   // Note that n_we follows the stored n_be only while n_wr is low
   // and n_ext_oe tracks n_wr exactly, so the bus is
   // driven only while data is being written

   // Read strobe timing is relative to the end of RW,
   // oete moves only the leading edge and is clipped to ws

   // Busy length per access
   //   write  ws+2 cycles
   //   read   ws+3 cycles, one extra for the FLOAT turnaround

endpackage

/* rtl/smc_access_reg.sv */
// Request is captured only on valid_access and must not arrive while an access is active
`timescale 1ns/10ps

module smc_access_reg
   import smc_pkg::*;
(
   input  logic     sys_clk12,
   input  logic     n_sys_reset12,
   input  logic     valid_access,   // One-cycle load strobe
   input  smc_req_t req,            // Raw request from the bus side
   input  logic     acc_done,       // Last cycle of the access
   output smc_req_t r_req,          // Held request for the whole access
   output logic     r_cs            // Held chip select, low between accesses
);

   // --------------------
   // Request store
   // --------------------
   // Bus inputs may change freely after the load edge,
   // strobes only ever look at this copy
   always_ff @(posedge sys_clk12)
   begin
      if (valid_access)
         r_req <= req;              // Load on the sampling edge E0
   end

   // --------------------
   // Chip select
   // --------------------
   // Set from the request at E0, dropped on the edge after acc_done
   // so it covers exactly the busy cycles
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
      begin
         r_cs <= 1'b0;
      end
      else if (valid_access)
      begin
         r_cs <= req.cs;            // New access
      end
      else if (acc_done)
      begin
         r_cs <= 1'b0;              // Access finished
      end
   end

   // Load and clear never meet here,
   // valid_access only comes in IDLE and acc_done never does

   // A low req.cs still runs a full access on the strobes,
   // only r_cs stays low for it

endmodule

/* rtl/smc_state_ctrl.sv */
// Single-access FSM with no back-pressure and valid_access assumed to come only while idle
`timescale 1ns/10ps

module smc_state_ctrl
   import smc_pkg::*;
(
   input  logic       sys_clk12,
   input  logic       n_sys_reset12,
   input  logic       valid_access,   // Start strobe, honored in IDLE only
   input  logic       n_read,         // Stored read/write flag
   input  logic       rw_last,        // Last wait-state cycle of RW
   output smc_state_t state,          // Current registered state
   output logic       acc_done,       // Final cycle of the access
   output logic       smc_busy        // High while an access runs
);

   smc_state_t next_state;

   // --------------------
   // Next state
   // --------------------
   always_comb
   begin
      next_state = state;                  // Hold by default
      case (state)
         SMC_IDLE:
         begin
            if (valid_access)
               next_state = SMC_LE;        // Address setup first
         end
         SMC_LE:
         begin
            next_state = SMC_RW;           // Always one setup cycle
         end
         SMC_RW:
         begin
            // Stretch until the counter reaches ws
            if (rw_last)
            begin
               if (n_read)
                  next_state = SMC_IDLE;   // Write ends here
               else
                  next_state = SMC_FLOAT;  // Read needs turnaround
            end
         end
         SMC_FLOAT:
         begin
            next_state = SMC_IDLE;
         end
         default:
         begin
            next_state = SMC_IDLE;
         end
      endcase
   end

   // Leaving to IDLE marks the last cycle of an access
   assign acc_done = (state != SMC_IDLE) && (next_state == SMC_IDLE);

   // --------------------
   // State and busy
   // --------------------
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
      begin
         state    <= SMC_IDLE;
         smc_busy <= 1'b0;
      end
      else
      begin
         state    <= next_state;
         smc_busy <= (next_state != SMC_IDLE);  // Busy rises with LE
      end
   end

   // --------------------
   // Checks
   // --------------------
   // Requester must wait for busy to fall, there is no stall path
   a_valid_in_idle : assert property (
      @(posedge sys_clk12) disable iff (!n_sys_reset12)
      valid_access |-> (state == SMC_IDLE) && !smc_busy
   )
   else
      $error("valid_access raised while an access is in progress");

endmodule

/* rtl/smc_wait_counter.sv */
// Counts RW cycles up to the stored ws and relies on ws being held for the whole access
`timescale 1ns/10ps

module smc_wait_counter
   import smc_pkg::*;
(
   input  logic                sys_clk12,
   input  logic                n_sys_reset12,
   input  smc_state_t          state,       // Current access state
   input  logic [SMC_WS_W-1:0] ws,          // Stored wait states
   output logic [SMC_WS_W-1:0] rw_count,    // RW cycles already spent
   output logic                rw_last      // This RW cycle is the last one
);

   // --------------------
   // RW cycle count
   // --------------------
   // Zero on entry to RW, steps once per RW cycle,
   // drops back to zero after the last one
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
         rw_count <= '0;
      else if ((state == SMC_RW) && !rw_last)
         rw_count <= rw_count + 1'b1;
      else
         rw_count <= '0;                    // Outside RW or leaving it
   end

   // Combinational so the FSM leaves RW in the same cycle
   assign rw_last = (rw_count == ws);

   // --------------------
   // Checks
   // --------------------
   // Relies on the access register keeping ws stable during RW
   a_count_in_range : assert property (
      @(posedge sys_clk12) disable iff (!n_sys_reset12)
      (state == SMC_RW) |-> (rw_count <= ws)
   )
   else
      $error("rw_count ran past the stored wait-state count");

endmodule

/* rtl/smc_strobe_gen.sv */
// Strobes lag the state by one cycle and full-cycle write strobes are the only write timing
`timescale 1ns/10ps

module smc_strobe_gen
   import smc_pkg::*;
(
   input  logic                sys_clk12,
   input  logic                n_sys_reset12,
   input  smc_state_t          state,       // Current access state
   input  logic [SMC_WS_W-1:0] rw_count,    // RW cycles already spent
   input  smc_req_t            r_req,       // Held request
   output smc_strobe_t         strobes      // Registered external strobes
);

   logic [SMC_WS_W-1:0] oete_ext;           // Read delay widened to count width
   logic [SMC_WS_W-1:0] rd_start;           // min(oete, ws)
   logic                in_rw;
   logic                is_write;
   logic                rd_on;
   smc_strobe_t         strobes_nxt;

   // --------------------
   // Read strobe window
   // --------------------
   assign oete_ext = {{(SMC_WS_W-SMC_OE_W){1'b0}}, r_req.oete};

   // Delay beyond ws would leave no read cycle so it is clipped
   assign rd_start = (oete_ext > r_req.ws) ? r_req.ws : oete_ext;

   assign in_rw    = (state == SMC_RW);
   assign is_write = r_req.n_read;          // High means write

   // Trailing edge fixed at end of RW and leading edge moved by oete
   assign rd_on = in_rw && !is_write && (rw_count >= rd_start);

   // --------------------
   // Strobe decode
   // --------------------
   always_comb
   begin
      strobes_nxt = '1;                     // All inactive by default
      if (in_rw && is_write)
      begin
         strobes_nxt.n_wr     = 1'b0;       // Whole RW phase
         strobes_nxt.n_ext_oe = 1'b0;       // Drive the data bus
         strobes_nxt.n_we     = r_req.n_be; // Only the enabled lanes
      end
      if (rd_on)
      begin
         strobes_nxt.n_rd = 1'b0;
      end
   end

   // --------------------
   // Output register
   // --------------------
   // Glitch-free pins one cycle behind state and count
   always_ff @(posedge sys_clk12 or negedge n_sys_reset12)
   begin
      if (!n_sys_reset12)
         strobes <= '1;                     // Everything high in reset
      else
         strobes <= strobes_nxt;
   end

   // Pins show ws+1 write cycles
   // and ws+1-min(oete, ws) read cycles
   // Both windows close two edges after the last RW cycle starts

   // --------------------
   // Checks
   // --------------------
   // Read and write must never drive the bus at once
   a_no_rd_wr_overlap : assert property (
      @(posedge sys_clk12) disable iff (!n_sys_reset12)
      !(!strobes.n_rd && !strobes.n_wr)
   )
   else
      $error("n_rd and n_wr low in the same cycle");

endmodule

/* rtl/smc_strobe_top.sv */
// Strobe section top for single accesses only with valid_access issued only while not busy
`timescale 1ns/10ps

module smc_strobe_top
   import smc_pkg::*;
(
   input  logic        sys_clk12,
   input  logic        n_sys_reset12,
   input  logic        valid_access,    // One-cycle request strobe
   input  smc_req_t    req,             // Request sampled with valid_access
   output smc_strobe_t strobes,         // External memory strobes
   output logic        smc_busy,        // Access in progress
   output logic        r_cs             // Held chip select
);

   smc_req_t            r_req;          // Request held for the access
   smc_state_t          state;          // Access state from the FSM
   logic                acc_done;       // Last cycle of the access
   logic [SMC_WS_W-1:0] rw_count;       // RW cycle count
   logic                rw_last;        // Last RW cycle

   // --------------------
   // Request hold
   // --------------------
   smc_access_reg u_access_reg (
      .sys_clk12     (sys_clk12),
      .n_sys_reset12 (n_sys_reset12),
      .valid_access  (valid_access),
      .req           (req),
      .acc_done      (acc_done),
      .r_req         (r_req),
      .r_cs          (r_cs)
   );

   // --------------------
   // Sequencing
   // --------------------
   smc_state_ctrl u_state_ctrl (
      .sys_clk12     (sys_clk12),
      .n_sys_reset12 (n_sys_reset12),
      .valid_access  (valid_access),
      .n_read        (r_req.n_read),
      .rw_last       (rw_last),
      .state         (state),
      .acc_done      (acc_done),
      .smc_busy      (smc_busy)
   );

   smc_wait_counter u_wait_counter (
      .sys_clk12     (sys_clk12),
      .n_sys_reset12 (n_sys_reset12),
      .state         (state),
      .ws            (r_req.ws),
      .rw_count      (rw_count),
      .rw_last       (rw_last)
   );

   // --------------------
   // Pin strobes
   // --------------------
   smc_strobe_gen u_strobe_gen (
      .sys_clk12     (sys_clk12),
      .n_sys_reset12 (n_sys_reset12),
      .state         (state),
      .rw_count      (rw_count),
      .r_req         (r_req),
      .strobes       (strobes)
   );

endmodule

/* tb/smc_tb_util.svh */
// Included inside smc_tb only, needs smc_pkg types and a fail_now task already in scope
`ifndef SMC_TB_UTIL_SVH
`define SMC_TB_UTIL_SVH

// --------------------
// Random source
// --------------------
logic [31:0] lfsr_state = 32'hdee0_3302;

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   logic [31:0] n;
   n = s >> 1;
   if (s[0])
      n = n ^ 32'h8020_0003;
   return n;
endfunction

// One LFSR step per bit taken, LSB of the state is the output bit
task automatic draw_bits(input int nbits, output logic [31:0] val);
   val = '0;
   for (int i = 0; i < nbits; i++)
   begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
   end
endtask

// --------------------
// Reference model
// --------------------
typedef struct packed
{
   logic [SMC_WS_W-1:0] busy_cyc;        // smc_busy high
   logic [SMC_WS_W-1:0] cs_cyc;          // r_cs high
   logic [SMC_WS_W-1:0] wr_cyc;          // n_wr low
   logic [SMC_WS_W-1:0] rd_cyc;          // n_rd low
   logic [SMC_WS_W-1:0] oe_cyc;          // n_ext_oe low
   logic [SMC_BE_W-1:0] n_we;            // Lane pattern while n_wr low
} expect_t;

// Cycle counts per access, straight from the external timing rules
function automatic expect_t smc_expect(input smc_req_t r);
   expect_t             e;
   logic [SMC_WS_W-1:0] rd_hold;         // Read strobe held off min(oete, ws)
   e = '0;
   e.n_we  = '1;
   rd_hold = r.ws;
   if (r.oete <= r.ws)
      rd_hold = r.oete;
   if (r.n_read)
   begin
      e.busy_cyc = r.ws + 2;             // LE plus ws+1 RW
      e.wr_cyc   = r.ws + 1;
      e.oe_cyc   = r.ws + 1;             // Bus driven with the write strobe
      e.n_we     = r.n_be;
   end
   else
   begin
      e.busy_cyc = r.ws + 3;             // Extra turnaround cycle
      e.rd_cyc   = r.ws + 1 - rd_hold;
   end
   e.cs_cyc = r.cs ? e.busy_cyc : '0;    // Low cs still runs the access
   return e;
endfunction

// --------------------
// Compare tasks
// --------------------
task automatic check_strobe(input smc_strobe_t actual, input smc_strobe_t expected,
                            input string what);
   if (actual !== expected)
      fail_now($sformatf("%s: strobes %b, expected %b", what, actual, expected));
endtask

task automatic check_count(input logic [SMC_WS_W-1:0] actual,
                           input logic [SMC_WS_W-1:0] expected, input string what);
   if (actual !== expected)
      fail_now($sformatf("%s: %0d cycles, expected %0d", what, actual, expected));
endtask

task automatic check_flag(input logic actual, input logic expected, input string what);
   if (actual !== expected)
      fail_now($sformatf("%s: got %b, expected %b", what, actual, expected));
endtask

`endif

/* tb/smc_tb.sv */
// One access in flight at a time with ws drawn from 0..15 and idle gaps from 0..7 cycles
`timescale 1ns/10ps

module smc_tb
   import smc_pkg::*;
();

   localparam int     CLK_NS      = 10;
   localparam int     RESET_CYC   = 5;
   localparam int     N_DIRECTED  = 13;     // One write plus 12 reads
   localparam int     N_RANDOM    = 200;
   localparam int     MAX_GAP     = 7;
   localparam longint WATCHDOG_NS = (N_DIRECTED + N_RANDOM) * (15 + 3 + MAX_GAP + 2) * CLK_NS
                                    + RESET_CYC * CLK_NS;

   logic        sys_clk12;
   logic        n_sys_reset12;
   logic        valid_access;
   smc_req_t    req;
   smc_strobe_t strobes;
   logic        smc_busy;
   logic        r_cs;
   int          error_count;

   task automatic fail_now(input string msg);
      error_count++;
      $display("** Error at time %0t: %s", $time, msg);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at first mismatch");
   endtask

   `include "smc_tb_util.svh"

   smc_req_t            pending_q[$];      // Issued and not yet checked
   int                  issued;
   int                  checked;
   logic                active;            // Monitor inside an access window
   expect_t             cur_exp;
   smc_strobe_t         wr_win;            // Expected pins during n_wr low
   logic [SMC_WS_W-1:0] busy_n;
   logic [SMC_WS_W-1:0] cs_n;
   logic [SMC_WS_W-1:0] wr_n;
   logic [SMC_WS_W-1:0] rd_n;
   logic [SMC_WS_W-1:0] oe_n;

   smc_strobe_top uut (
      .sys_clk12     (sys_clk12),
      .n_sys_reset12 (n_sys_reset12),
      .valid_access  (valid_access),
      .req           (req),
      .strobes       (strobes),
      .smc_busy      (smc_busy),
      .r_cs          (r_cs)
   );

   always #(CLK_NS / 2) sys_clk12 = ~sys_clk12;

   // --------------------
   // Stimulus
   // --------------------
   function automatic smc_req_t make_req(input logic cs, input logic n_read,
                                         input logic [SMC_BE_W-1:0] n_be,
                                         input int ws, input int oete);
      smc_req_t r;
      r.cs     = cs;
      r.n_read = n_read;
      r.n_be   = n_be;
      r.ws     = ws[SMC_WS_W-1:0];
      r.oete   = oete[SMC_OE_W-1:0];
      return r;
   endfunction

   // Entered 1 ns after an edge and returns the same way
   task automatic issue_access(input smc_req_t r, input int gap);
      pending_q.push_back(r);
      issued++;
      req          = r;
      valid_access = 1'b1;
      @(posedge sys_clk12);
      #1;
      valid_access = 1'b0;
      req          = ~r;                      // Bus moves on while the stored copy holds
      while (smc_busy)
      begin
         @(posedge sys_clk12);
         #1;
      end
      repeat (gap)
      begin
         @(posedge sys_clk12);
         #1;
      end
   endtask

   task automatic random_access();
      logic [31:0] v;
      smc_req_t    r;
      int          gap;
      draw_bits(1, v);
      r.n_read = v[0];
      draw_bits(1, v);
      r.cs = v[0];
      draw_bits(SMC_BE_W, v);
      r.n_be = v[SMC_BE_W-1:0];
      draw_bits(4, v);
      r.ws = {{(SMC_WS_W-4){1'b0}}, v[3:0]};  // 0..15 only
      draw_bits(SMC_OE_W, v);
      r.oete = v[SMC_OE_W-1:0];
      draw_bits(3, v);
      gap = int'(v[2:0]);
      issue_access(r, gap);
   endtask

   initial
   begin
      sys_clk12     = 1'b0;
      n_sys_reset12 = 1'b0;
      valid_access  = 1'b0;
      req           = '0;
      error_count   = 0;
      issued        = 0;
      checked       = 0;
      active        = 1'b0;
      repeat (RESET_CYC) @(posedge sys_clk12);
      #1;
      n_sys_reset12 = 1'b1;
      @(negedge sys_clk12);
      check_strobe(strobes, '1, "after reset");    // Idle pins
      check_flag(smc_busy, 1'b0, "smc_busy after reset");
      check_flag(r_cs, 1'b0, "r_cs after reset");
      @(posedge sys_clk12);
      #1;
      issue_access(make_req(1'b1, 1'b1, 4'b0101, 0, 0), 1);  // Shortest write
      // Every oete against short and long ws with cs toggling
      for (int w = 0; w < 3; w++)
      begin
         for (int oe = 0; oe < 4; oe++)
            issue_access(make_req(oe[0], 1'b0, 4'hf, (w == 2) ? 5 : w, oe), 1);
      end
      for (int k = 0; k < N_RANDOM; k++)
         random_access();
      wait (checked == issued);
      @(posedge sys_clk12);
      if (error_count == 0)
      begin
         $display("=== PASS ===");
         $finish;
      end
      else
      begin
         $display("=== FAIL ===");
         $fatal(1, "Checks failed");
      end
   end

   // --------------------
   // Monitor
   // --------------------
   // Samples at the falling edge and runs one cycle past busy for the write trailing edge
   always @(negedge sys_clk12)
   begin
      if (n_sys_reset12)
      begin
         check_flag(!strobes.n_rd && !strobes.n_wr, 1'b0, "n_rd and n_wr low together");
         check_flag(r_cs && !smc_busy, 1'b0, "r_cs high outside busy");
         if (smc_busy || active)
         begin
            if (!active)
            begin
               if (pending_q.size() == 0)
                  fail_now("smc_busy rose with no access issued");
               active  = 1'b1;
               cur_exp = smc_expect(pending_q[0]);
               busy_n  = '0;
               cs_n    = '0;
               wr_n    = '0;
               rd_n    = '0;
               oe_n    = '0;
               wr_win  = '1;
               wr_win.n_ext_oe = 1'b0;
               wr_win.n_wr     = 1'b0;
               wr_win.n_we     = cur_exp.n_we;
            end
            busy_n += smc_busy;
            cs_n   += r_cs;
            wr_n   += !strobes.n_wr;
            rd_n   += !strobes.n_rd;
            oe_n   += !strobes.n_ext_oe;
            if (!strobes.n_wr)
               check_strobe(strobes, wr_win, "write window");
            else
               check_flag((strobes.n_we == '1) && strobes.n_ext_oe, 1'b1,
                          "n_we or n_ext_oe low without n_wr");
            if (!smc_busy)
            begin
               check_count(busy_n, cur_exp.busy_cyc, "smc_busy");
               check_count(cs_n, cur_exp.cs_cyc, "r_cs");
               check_count(wr_n, cur_exp.wr_cyc, "n_wr low");
               check_count(rd_n, cur_exp.rd_cyc, "n_rd low");
               check_count(oe_n, cur_exp.oe_cyc, "n_ext_oe low");
               void'(pending_q.pop_front());
               checked++;
               active = 1'b0;
            end
         end
         else
         begin
            check_strobe(strobes, '1, "between accesses");
         end
      end
   end

   // --------------------
   // Watchdog
   // --------------------
   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the accesses did not all complete within %0d ns", WATCHDOG_NS);
      $display("=== FAIL ===");
      $fatal(1, "Watchdog expired");
   end

endmodule

/* tb.f */
+incdir+tb
rtl/smc_pkg.sv
rtl/smc_access_reg.sv
rtl/smc_state_ctrl.sv
rtl/smc_wait_counter.sv
rtl/smc_strobe_gen.sv
rtl/smc_strobe_top.sv
tb/smc_tb.sv

/* Bender.yml */
package:
  name: smc_strobe

sources:
  - files:
      - rtl/smc_pkg.sv
      - rtl/smc_access_reg.sv
      - rtl/smc_state_ctrl.sv
      - rtl/smc_wait_counter.sv
      - rtl/smc_strobe_gen.sv
      - rtl/smc_strobe_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/smc_tb.sv
